//--- tft_shield_pkg.sv
`default_nettype none

package tft_shield_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;      // One SPI byte
  typedef logic [31:0] bus_data_t;  // Bus data word
  typedef logic [3:0]  reg_addr_t;  // Register index inside a controller

  //////////////////////////////////////////////////////////////////////
  // Bus request and response
  //////////////////////////////////////////////////////////////////////

  // Held by the host until ack comes back
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    bus_data_t dat;
  } bus_req_t;

  // Single cycle ack with read data alongside
  typedef struct packed {
    logic      ack;
    bus_data_t dat;
  } bus_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // Display controller
  localparam reg_addr_t LCD_CMD_ADDR  = 4'd0;  // Byte sent with DC low
  localparam reg_addr_t LCD_DATA_ADDR = 4'd1;  // Byte sent with DC high

  // SD card controller
  localparam reg_addr_t SD_DATA_ADDR  = 4'd0;  // Write sends, read gives last rx byte
  localparam reg_addr_t SD_CTRL_ADDR  = 4'd1;  // Bit 0 keeps CS asserted

  // Common to both controllers
  localparam reg_addr_t STATUS_ADDR   = 4'd2;  // Bit 0 is busy

endpackage

`default_nettype wire

//--- lcd_spi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_spi_ctrl #(
  parameter int CLK_DIV = 2
) (
  input  logic                     clk,
  input  logic                     reset_i,
  input  tft_shield_pkg::bus_req_t bus_i,
  output tft_shield_pkg::bus_rsp_t bus_o,
  output logic                     spi_req_o,
  input  logic                     spi_ack_i,
  output logic                     spi_done_o,
  output logic                     sck_o,
  output logic                     cs_o,
  output logic                     dc_o,
  output logic                     mosi_o
);

  import tft_shield_pkg::*;

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  typedef enum logic [2:0] {IDLE, REQ, SETUP, SHIFT, HOLD} state_e;

  state_e           state_q;
  logic [DIV_W-1:0] div_q;
  logic [2:0]       bit_q;
  byte_t            shift_q;
  logic             ack_q;
  bus_data_t        rdat_q;

  logic sel;
  logic byte_wr;
  logic accept;
  logic half_tick;
  logic busy;

  //////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////

  assign sel     = bus_i.cyc && bus_i.stb && !ack_q;  // Ignore stb in the ack cycle
  assign byte_wr = sel && bus_i.we &&
                   (bus_i.adr == LCD_CMD_ADDR || bus_i.adr == LCD_DATA_ADDR);
  assign accept  = byte_wr && (state_q == IDLE);
  assign busy    = (state_q != IDLE);

  // Byte writes wait for the shifter to go idle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sel && (!byte_wr || state_q == IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (sel && !bus_i.we) begin
      rdat_q <= (bus_i.adr == STATUS_ADDR) ? bus_data_t'(busy) : '0;
    end
  end

  assign bus_o.ack = ack_q;
  assign bus_o.dat = rdat_q;

  //////////////////////////////////////////////////////////////////////
  // SPI shifter
  //////////////////////////////////////////////////////////////////////

  assign half_tick = (div_q == DIV_W'(CLK_DIV - 1));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      div_q <= '0;
    end else if (state_q == IDLE || state_q == REQ || half_tick) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= IDLE;
      spi_req_o  <= 1'b0;
      spi_done_o <= 1'b0;
      sck_o      <= 1'b0;
      cs_o       <= 1'b1;
      bit_q      <= '0;
    end else begin
      spi_done_o <= 1'b0;
      case (state_q)
        IDLE: if (accept) begin
          state_q   <= REQ;
          spi_req_o <= 1'b1;
        end
        REQ: if (spi_ack_i) begin
          state_q <= SETUP;
          cs_o    <= 1'b0;
        end
        SETUP: if (half_tick) state_q <= SHIFT;
        SHIFT: if (half_tick) begin
          sck_o <= ~sck_o;
          if (sck_o) begin  // Falling edge ends a bit
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= HOLD;
          end
        end
        HOLD: if (half_tick) begin
          state_q    <= IDLE;
          cs_o       <= 1'b1;
          spi_req_o  <= 1'b0;
          spi_done_o <= 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= bus_i.dat[7:0];
      dc_o    <= (bus_i.adr == LCD_DATA_ADDR);
    end else if (state_q == SHIFT && half_tick && sck_o) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign mosi_o = shift_q[7];  // MSB first

endmodule

`default_nettype wire

//--- sdcard_spi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sdcard_spi_ctrl #(
  parameter int CLK_DIV = 2
) (
  input  logic                     clk,
  input  logic                     reset_i,
  input  tft_shield_pkg::bus_req_t bus_i,
  output tft_shield_pkg::bus_rsp_t bus_o,
  output logic                     spi_req_o,
  input  logic                     spi_ack_i,
  output logic                     spi_done_o,
  output logic                     sck_o,
  output logic                     cs_o,
  output logic                     mosi_o,
  input  logic                     miso_i
);

  import tft_shield_pkg::*;

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  typedef enum logic [2:0] {IDLE, REQ, SETUP, SHIFT, HOLD} state_e;

  state_e           state_q;
  logic [DIV_W-1:0] div_q;
  logic [2:0]       bit_q;
  byte_t            shift_q;
  byte_t            rx_q;
  logic             miso_q;
  logic             hold_q;
  logic             ack_q;
  bus_data_t        rdat_q;

  logic sel;
  logic byte_wr;
  logic accept;
  logic half_tick;
  logic busy;

  //////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////

  assign sel     = bus_i.cyc && bus_i.stb && !ack_q;
  assign byte_wr = sel && bus_i.we && (bus_i.adr == SD_DATA_ADDR);
  assign accept  = byte_wr && (state_q == IDLE);
  assign busy    = (state_q != IDLE);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q  <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      ack_q <= sel && (!byte_wr || state_q == IDLE);
      if (sel && bus_i.we && bus_i.adr == SD_CTRL_ADDR) hold_q <= bus_i.dat[0];
    end
  end

  always_ff @(posedge clk) begin
    if (sel && !bus_i.we) begin
      case (bus_i.adr)
        SD_DATA_ADDR: rdat_q <= bus_data_t'(rx_q);
        SD_CTRL_ADDR: rdat_q <= bus_data_t'(hold_q);
        STATUS_ADDR:  rdat_q <= bus_data_t'(busy);
        default:      rdat_q <= '0;
      endcase
    end
  end

  assign bus_o.ack = ack_q;
  assign bus_o.dat = rdat_q;

  //////////////////////////////////////////////////////////////////////
  // SPI shifter
  //////////////////////////////////////////////////////////////////////

  assign half_tick = (div_q == DIV_W'(CLK_DIV - 1));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      div_q <= '0;
    end else if (state_q == IDLE || state_q == REQ || half_tick) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= IDLE;
      spi_req_o  <= 1'b0;
      spi_done_o <= 1'b0;
      sck_o      <= 1'b0;
      cs_o       <= 1'b1;
      bit_q      <= '0;
    end else begin
      spi_done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          cs_o <= !hold_q;  // Hold bit keeps the card selected between bytes
          if (accept) begin
            state_q   <= REQ;
            spi_req_o <= 1'b1;
          end
        end
        REQ: if (spi_ack_i) begin
          state_q <= SETUP;
          cs_o    <= 1'b0;
        end
        SETUP: if (half_tick) state_q <= SHIFT;
        SHIFT: if (half_tick) begin
          sck_o <= ~sck_o;
          if (sck_o) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= HOLD;
          end
        end
        HOLD: if (half_tick) begin
          state_q    <= IDLE;
          cs_o       <= !hold_q;
          spi_req_o  <= 1'b0;  // Bus is released after every byte
          spi_done_o <= 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Sample on the rising edge, shift on the falling edge
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= bus_i.dat[7:0];
    end else if (state_q == SHIFT && half_tick) begin
      if (!sck_o) begin
        miso_q <= miso_i;
      end else begin
        shift_q <= {shift_q[6:0], miso_q};
        if (bit_q == 3'd7) rx_q <= {shift_q[6:0], miso_q};
      end
    end
  end

  assign mosi_o = shift_q[7];

endmodule

`default_nettype wire

//--- spi_arb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_arb (
  input  logic clk,
  input  logic reset_i,

  input  logic lcd_req_i,
  input  logic lcd_done_i,
  output logic lcd_ack_o,
  input  logic lcd_sck_i,
  input  logic lcd_cs_i,
  input  logic lcd_dc_i,
  input  logic lcd_mosi_i,

  input  logic sd_req_i,
  input  logic sd_done_i,
  output logic sd_ack_o,
  input  logic sd_sck_i,
  input  logic sd_cs_i,
  input  logic sd_mosi_i,

  output logic sck_o,
  output logic lcd_cs_o,
  output logic sd_cs_o,
  output logic dc_o,
  output logic mosi_o
);

  typedef enum logic [1:0] {NONE, LCD, SD} owner_e;

  owner_e owner_q;
  logic   last_sd_q;  // SD card was served last

  logic lcd_own;
  logic sd_own;

  //////////////////////////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      owner_q   <= NONE;
      last_sd_q <= 1'b0;
    end else begin
      case (owner_q)
        NONE: begin
          // On a tie the master not served last goes first
          if (lcd_req_i && (!sd_req_i || last_sd_q)) begin
            owner_q   <= LCD;
            last_sd_q <= 1'b0;
          end else if (sd_req_i) begin
            owner_q   <= SD;
            last_sd_q <= 1'b1;
          end
        end
        LCD: if (lcd_done_i) owner_q <= NONE;
        SD:  if (sd_done_i) owner_q <= NONE;
        default: owner_q <= NONE;
      endcase
    end
  end

  assign lcd_own   = (owner_q == LCD);
  assign sd_own    = (owner_q == SD);
  assign lcd_ack_o = lcd_own;
  assign sd_ack_o  = sd_own;

  //////////////////////////////////////////////////////////////////////
  // Pin multiplexer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sck_o  = 1'b0;  // Idle bus keeps SCK low
    dc_o   = 1'b0;
    mosi_o = 1'b0;
    if (lcd_own) begin
      sck_o  = lcd_sck_i;
      dc_o   = lcd_dc_i;
      mosi_o = lcd_mosi_i;
    end else if (sd_own) begin
      sck_o  = sd_sck_i;
      mosi_o = sd_mosi_i;
    end
  end

  assign lcd_cs_o = lcd_own ? lcd_cs_i : 1'b1;
  assign sd_cs_o  = lcd_own ? 1'b1 : sd_cs_i;  // Lets the hold bit work between bytes

endmodule

`default_nettype wire

//--- tft_touch_shield.sv
`timescale 1ns/1ps
`default_nettype none

module tft_touch_shield #(
  parameter int CLK_DIV = 2
) (
  input  logic                     clk,
  input  logic                     reset_i,

  input  tft_shield_pkg::bus_req_t display_bus_i,
  output tft_shield_pkg::bus_rsp_t display_bus_o,
  input  tft_shield_pkg::bus_req_t sdcard_bus_i,
  output tft_shield_pkg::bus_rsp_t sdcard_bus_o,

  output logic [15:0]              arduino_io_o,
  input  logic                     arduino_miso_i,
  input  logic                     arduino_reset_n_i,
  output logic                     arst_o
);

  logic lcd_req, lcd_ack, lcd_done, lcd_sck, lcd_cs, lcd_dc, lcd_mosi;
  logic sd_req, sd_ack, sd_done, sd_sck, sd_cs, sd_mosi;
  logic pin_sck, pin_lcd_cs, pin_sd_cs, pin_dc, pin_mosi;

  lcd_spi_ctrl #(.CLK_DIV(CLK_DIV)) display (
    .clk        (clk),
    .reset_i    (reset_i),
    .bus_i      (display_bus_i),
    .bus_o      (display_bus_o),
    .spi_req_o  (lcd_req),
    .spi_ack_i  (lcd_ack),
    .spi_done_o (lcd_done),
    .sck_o      (lcd_sck),
    .cs_o       (lcd_cs),
    .dc_o       (lcd_dc),
    .mosi_o     (lcd_mosi)
  );

  sdcard_spi_ctrl #(.CLK_DIV(CLK_DIV)) sdcard (
    .clk        (clk),
    .reset_i    (reset_i),
    .bus_i      (sdcard_bus_i),
    .bus_o      (sdcard_bus_o),
    .spi_req_o  (sd_req),
    .spi_ack_i  (sd_ack),
    .spi_done_o (sd_done),
    .sck_o      (sd_sck),
    .cs_o       (sd_cs),
    .mosi_o     (sd_mosi),
    .miso_i     (arduino_miso_i)  // Pin 12
  );

  spi_arb arb (
    .clk        (clk),
    .reset_i    (reset_i),
    .lcd_req_i  (lcd_req),
    .lcd_done_i (lcd_done),
    .lcd_ack_o  (lcd_ack),
    .lcd_sck_i  (lcd_sck),
    .lcd_cs_i   (lcd_cs),
    .lcd_dc_i   (lcd_dc),
    .lcd_mosi_i (lcd_mosi),
    .sd_req_i   (sd_req),
    .sd_done_i  (sd_done),
    .sd_ack_o   (sd_ack),
    .sd_sck_i   (sd_sck),
    .sd_cs_i    (sd_cs),
    .sd_mosi_i  (sd_mosi),
    .sck_o      (pin_sck),
    .lcd_cs_o   (pin_lcd_cs),
    .sd_cs_o    (pin_sd_cs),
    .dc_o       (pin_dc),
    .mosi_o     (pin_mosi)
  );

  //////////////////////////////////////////////////////////////////////
  // Header pins
  //////////////////////////////////////////////////////////////////////

  assign arduino_io_o[3:0]   = '0;
  assign arduino_io_o[4]     = 1'b1;        // Touch panel CS idle
  assign arduino_io_o[5]     = pin_sd_cs;
  assign arduino_io_o[6]     = 1'b0;
  assign arduino_io_o[7]     = pin_dc;
  assign arduino_io_o[8]     = ~reset_i;    // LCD reset
  assign arduino_io_o[9]     = 1'b1;        // Backlight
  assign arduino_io_o[10]    = pin_lcd_cs;
  assign arduino_io_o[11]    = pin_mosi;
  assign arduino_io_o[12]    = 1'b0;        // MISO comes in on its own port
  assign arduino_io_o[13]    = pin_sck;
  assign arduino_io_o[14]    = 1'b0;        // GND
  assign arduino_io_o[15]    = 1'b0;

  assign arst_o = ~arduino_reset_n_i;

endmodule

`default_nettype wire

//--- tft_touch_shield_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tft_touch_shield_properties (
  input logic clk,
  input logic reset_i,
  input logic lcd_req_i,
  input logic sd_req_i,
  input logic lcd_ack_o,
  input logic sd_ack_o,
  input logic lcd_sck_i,
  input logic sd_sck_i,
  input logic lcd_cs_i,
  input logic sck_o,
  input logic lcd_cs_o,
  input logic sd_cs_o
);

  //////////////////////////////////////////////////////////////////////
  // Chip selects and grants
  //////////////////////////////////////////////////////////////////////

  // LCD select only under its own grant, with the SD card deselected
  cs_exclusive: assert property (@(posedge clk) disable iff (reset_i)
    !lcd_cs_i |-> (lcd_ack_o && sd_cs_o))
    else $error("LCD chip select low without grant or together with SD card select");

  lcd_grant_after_req: assert property (@(posedge clk) disable iff (reset_i)
    $rose(lcd_ack_o) |-> $past(lcd_req_i))
    else $error("LCD grant without a request");

  sd_grant_after_req: assert property (@(posedge clk) disable iff (reset_i)
    $rose(sd_ack_o) |-> $past(sd_req_i))
    else $error("SD card grant without a request");

  // Idle bus, masters included
  sck_idle_low: assert property (@(posedge clk) disable iff (reset_i)
    (!lcd_ack_o && !sd_ack_o) |-> !(sck_o || lcd_sck_i || sd_sck_i))
    else $error("SCK high while no master owns the bus");

endmodule

bind spi_arb tft_touch_shield_properties props (.*);

`default_nettype wire

//--- tb_tft_touch_shield.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tft_touch_shield;

  import tft_shield_pkg::*;

  localparam int CLK_DIV = 2;
  localparam int N       = 14;
  localparam logic [2:0] K_RD = 3'd0, K_CFG = 3'd1, K_WR = 3'd2;
  localparam logic [2:0] K_WR2 = 3'd3, K_RX = 3'd4, K_BOTH = 3'd5;
  localparam logic DISP = 1'b0, SD = 1'b1;

  // Bytes in dat and exp_byte are first byte in [15:8], second in [7:0]
  typedef struct packed {
    logic [2:0]  kind;
    logic        tgt;
    logic        we;
    reg_addr_t   adr;
    logic [15:0] dat;
    logic [15:0] exp_byte;
    logic        exp_dc;
    logic [7:0]  exp_rd;
    logic        exp_cs;  // Pin 5 level once the op is over
  } entry_t;

  logic        clk;
  logic        reset_i;
  bus_req_t    display_bus_i;
  bus_rsp_t    display_bus_o;
  bus_req_t    sdcard_bus_i;
  bus_rsp_t    sdcard_bus_o;
  logic [15:0] io;
  logic        arduino_miso_i;
  logic        arduino_reset_n_i;
  logic        arst_o;

  entry_t tbl [N];
  int     errors;
  int     sd_cs_rises = 0;
  byte_t  lcd_rx[$];
  logic   lcd_dcs[$];
  byte_t  sd_rx[$];
  byte_t  lcd_sh, sd_sh, miso_byte;
  logic [2:0] lcd_n = '0;
  logic [2:0] sd_n = '0;

  tft_touch_shield #(.CLK_DIV(CLK_DIV)) UUT (
    .clk               (clk),
    .reset_i           (reset_i),
    .display_bus_i     (display_bus_i),
    .display_bus_o     (display_bus_o),
    .sdcard_bus_i      (sdcard_bus_i),
    .sdcard_bus_o      (sdcard_bus_o),
    .arduino_io_o      (io),
    .arduino_miso_i    (arduino_miso_i),
    .arduino_reset_n_i (arduino_reset_n_i),
    .arst_o            (arst_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // SPI slave models
  //////////////////////////////////////////////////////////////////////

  always @(posedge io[13]) begin
    if (!io[10]) begin
      lcd_sh = {lcd_sh[6:0], io[11]};
      if (lcd_n == 3'd7) begin
        lcd_rx.push_back(lcd_sh);
        lcd_dcs.push_back(io[7]);
      end
      lcd_n = lcd_n + 1'b1;
    end
    if (!io[5]) begin
      sd_sh = {sd_sh[6:0], io[11]};
      if (sd_n == 3'd7) sd_rx.push_back(sd_sh);
      sd_n = sd_n + 1'b1;
    end
  end

  always @(posedge io[5]) sd_cs_rises = sd_cs_rises + 1;

  assign arduino_miso_i = miso_byte[3'd7 - sd_n];  // Next bit ready before SCK rises

  //////////////////////////////////////////////////////////////////////
  // Bus drivers and checks
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s: got %h expected %h", $time, name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic display_xfer(input logic we, input reg_addr_t adr, input bus_data_t dat,
                              output bus_data_t rd);
    @(negedge clk);
    display_bus_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do @(negedge clk); while (!display_bus_o.ack);
    rd = display_bus_o.dat;
    display_bus_i = '0;
  endtask

  task automatic sdcard_xfer(input logic we, input reg_addr_t adr, input bus_data_t dat,
                             output bus_data_t rd);
    @(negedge clk);
    sdcard_bus_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do @(negedge clk); while (!sdcard_bus_o.ack);
    rd = sdcard_bus_o.dat;
    sdcard_bus_i = '0;
  endtask

  task automatic bus_op(input logic tgt, input logic we, input reg_addr_t adr,
                        input bus_data_t dat, output bus_data_t rd);
    if (tgt == SD) sdcard_xfer(we, adr, dat, rd);
    else display_xfer(we, adr, dat, rd);
  endtask

  task automatic wait_idle(input logic tgt);
    bus_data_t rd;
    rd = 32'd1;
    while (rd[0]) bus_op(tgt, 1'b0, STATUS_ADDR, '0, rd);
  endtask

  task automatic expect_lcd(input int idx, input int total, input byte_t b, input logic dc);
    check("lcd byte count", 32'(lcd_rx.size()), 32'(total));
    if (lcd_rx.size() > idx) begin
      check("pin11 lcd byte", 32'(lcd_rx[idx]), 32'(b));
      check("pin7", 32'(lcd_dcs[idx]), 32'(dc));
    end
  endtask

  task automatic expect_sd(input int idx, input byte_t b);
    check("sd byte count", 32'(sd_rx.size()), 32'(idx + 1));
    if (sd_rx.size() > idx) check("pin11 sd byte", 32'(sd_rx[idx]), 32'(b));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  initial begin
    tbl[0]  = '{K_RD,   DISP, 1'b0, STATUS_ADDR,   16'h0,    16'h0,    1'b0, 8'h0, 1'b1};
    tbl[1]  = '{K_RD,   SD,   1'b0, STATUS_ADDR,   16'h0,    16'h0,    1'b0, 8'h0, 1'b1};
    tbl[2]  = '{K_WR,   DISP, 1'b1, LCD_CMD_ADDR,  16'h2a,   16'h2a,   1'b0, 8'h0, 1'b1};
    tbl[3]  = '{K_WR,   DISP, 1'b1, LCD_DATA_ADDR, 16'h5c,   16'h5c,   1'b1, 8'h0, 1'b1};
    tbl[4]  = '{K_WR2,  DISP, 1'b1, LCD_DATA_ADDR, 16'ha13b, 16'ha13b, 1'b1, 8'h0, 1'b1};
    tbl[5]  = '{K_WR,   SD,   1'b1, SD_DATA_ADDR,  16'h51,   16'h51,   1'b0, 8'h0, 1'b1};
    tbl[6]  = '{K_RX,   SD,   1'b0, SD_DATA_ADDR,  16'h0,    16'h0,    1'b0, 8'h0, 1'b1};
    tbl[7]  = '{K_CFG,  SD,   1'b1, SD_CTRL_ADDR,  16'h1,    16'h0,    1'b0, 8'h0, 1'b0};
    tbl[8]  = '{K_WR,   SD,   1'b1, SD_DATA_ADDR,  16'hc3,   16'hc3,   1'b0, 8'h0, 1'b0};
    tbl[9]  = '{K_WR,   SD,   1'b1, SD_DATA_ADDR,  16'h7e,   16'h7e,   1'b0, 8'h0, 1'b0};
    tbl[10] = '{K_CFG,  SD,   1'b1, SD_CTRL_ADDR,  16'h0,    16'h0,    1'b0, 8'h0, 1'b1};
    tbl[11] = '{K_WR,   SD,   1'b1, SD_DATA_ADDR,  16'h99,   16'h99,   1'b0, 8'h0, 1'b1};
    tbl[12] = '{K_BOTH, DISP, 1'b1, LCD_CMD_ADDR,  16'h1234, 16'h1234, 1'b0, 8'h0, 1'b1};
    tbl[13] = '{K_RX,   SD,   1'b0, SD_DATA_ADDR,  16'h0,    16'h0,    1'b0, 8'h0, 1'b1};
  end

  // Watchdog
  initial begin
    repeat (N * (20 * CLK_DIV + 40) + 20) @(posedge clk);
    $display("Timeout: the DUT did not finish the table in time");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    entry_t    e;
    bus_data_t rd;
    bus_data_t rd2;
    int        errs0, rises0, nl, ns;
    void'($urandom(32'h7dec_8a61));
    errors            = 0;
    miso_byte         = 8'h00;
    reset_i           = 1'b1;
    display_bus_i     = '0;
    sdcard_bus_i      = '0;
    arduino_reset_n_i = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    check("pin8", 32'(io[8]), 32'd0);
    check("arst_o", 32'(arst_o), 32'd1);
    reset_i           = 1'b0;
    arduino_reset_n_i = 1'b1;
    @(negedge clk);
    check("pin8", 32'(io[8]), 32'd1);
    check("pins 14 9 4", 32'({io[14], io[9], io[4]}), 32'b011);
    check("pins 13 10 5", 32'({io[13], io[10], io[5]}), 32'b011);
    check("pins 15 12 6 3:0", 32'({io[15], io[12], io[6], io[3:0]}), 32'd0);
    check("arst_o", 32'(arst_o), 32'd0);
    arduino_reset_n_i = 1'b0;  // Header reset on its own
    @(negedge clk);
    check("arst_o", 32'(arst_o), 32'd1);
    check("pin8", 32'(io[8]), 32'd1);
    arduino_reset_n_i = 1'b1;
    $display("test reset %s", (errors == 0) ? "ok" : "failed");

    for (int i = 0; i < N; i++) begin
      e      = tbl[i];
      errs0  = errors;
      rises0 = sd_cs_rises;
      nl     = lcd_rx.size();
      ns     = sd_rx.size();
      if (e.tgt == SD && e.kind == K_WR) miso_byte = byte_t'($urandom);
      case (e.kind)
        K_RD: begin
          bus_op(e.tgt, e.we, e.adr, '0, rd);
          check("bus_o.dat", rd, 32'(e.exp_rd));
        end
        K_CFG: begin
          bus_op(e.tgt, e.we, e.adr, 32'(e.dat), rd);
          @(negedge clk);  // Chip select register follows the hold bit one cycle later
        end
        K_WR: begin
          bus_op(e.tgt, e.we, e.adr, 32'(e.dat[7:0]), rd);
          wait_idle(e.tgt);
          if (e.tgt == DISP) expect_lcd(nl, nl + 1, e.exp_byte[7:0], e.exp_dc);
          else expect_sd(ns, e.exp_byte[7:0]);
        end
        K_WR2: begin
          display_xfer(1'b1, e.adr, 32'(e.dat[15:8]), rd);
          display_xfer(1'b1, e.adr, 32'(e.dat[7:0]), rd);
          check("lcd bytes at second ack", 32'(lcd_rx.size()), 32'(nl + 1));
          wait_idle(DISP);
          expect_lcd(nl, nl + 2, e.exp_byte[15:8], e.exp_dc);
          expect_lcd(nl + 1, nl + 2, e.exp_byte[7:0], e.exp_dc);
        end
        K_RX: begin
          bus_op(SD, 1'b0, SD_DATA_ADDR, '0, rd);
          check("sd rx byte", rd, 32'(miso_byte));
        end
        default: begin  // Both masters start in the same cycle
          miso_byte = byte_t'($urandom);
          fork
            display_xfer(1'b1, e.adr, 32'(e.dat[15:8]), rd);
            sdcard_xfer(1'b1, SD_DATA_ADDR, 32'(e.dat[7:0]), rd2);
          join
          wait_idle(DISP);
          wait_idle(SD);
          expect_lcd(nl, nl + 1, e.exp_byte[15:8], e.exp_dc);
          expect_sd(ns, e.exp_byte[7:0]);
        end
      endcase
      check("pin5", 32'(io[5]), 32'(e.exp_cs));
      if (!e.exp_cs) check("pin5 rises", 32'(sd_cs_rises), 32'(rises0));
      $display("test %0d %s", i, (errors == errs0) ? "ok" : "failed");
    end

    $display("Summary: %0d tests, %0d errors", N + 1, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
tft_shield_pkg.sv
lcd_spi_ctrl.sv
sdcard_spi_ctrl.sv
spi_arb.sv
tft_touch_shield.sv
tft_touch_shield_properties.sv
tb_tft_touch_shield.sv

//--- Makefile
TOP = tb_tft_touch_shield

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
